//--- logic/fieldPkg.sv
package fieldPkg;

        ////////////////////////////////////////////////////////////////////////
        // P-256 field sizes
        ////////////////////////////////////////////////////////////////////////

        localparam int ElementWidth = 256;
        localparam int ProductWidth = 2 * ElementWidth;  // full 256x256 product

        // operands and reduced results
        typedef logic [ElementWidth-1:0] element;

        // unreduced multiplier output
        typedef logic [ProductWidth-1:0] product;

        ////////////////////////////////////////////////////////////////////////
        // field prime p = 2^256 - 2^224 + 2^192 + 2^96 - 1
        ////////////////////////////////////////////////////////////////////////

        localparam element Prime =
                256'hffffffff_00000001_00000000_00000000_00000000_ffffffff_ffffffff_ffffffff;

endpackage

//--- logic/commandPkg.sv
package commandPkg;

        // operation select
        typedef enum logic [1:0] {
                opAdd = 2'd0,
                opSub = 2'd1,
                opMul = 2'd2
        } fieldOp;

        // one command, operands already below the prime
        typedef struct packed {
                fieldOp           op;
                fieldPkg::element a;
                fieldPkg::element b;
        } fieldCmd;

        // value plus the op that made it
        typedef struct packed {
                fieldPkg::element value;
                fieldOp           op;
        } fieldResult;

endpackage

//--- logic/modAddSub.sv
`timescale 1ns/1ns

module modAddSub (
        input  logic             clk,
        input  logic             start,
        input  logic             asStart,
        input  logic             asSubtract,
        input  fieldPkg::element asA,
        input  fieldPkg::element asB,
        output fieldPkg::element asSum
);

        localparam int W = fieldPkg::ElementWidth;

        logic [W:0] sumWide;    // carry in top bit
        logic [W:0] diffWide;   // borrow in top bit
        logic [W:0] sumFold;
        logic [W:0] diffFold;
        logic       sumOver;

        assign sumWide  = {1'b0, asA} + {1'b0, asB};
        assign diffWide = {1'b0, asA} - {1'b0, asB};
        assign sumFold  = sumWide - {1'b0, fieldPkg::Prime};
        assign diffFold = diffWide + {1'b0, fieldPkg::Prime};

        // carry out, or landed on/above p
        assign sumOver = sumWide[W] || (sumWide[W-1:0] >= fieldPkg::Prime);

        always_ff @(posedge clk or negedge start) begin
                if (!start) begin
                        asSum <= '0;
                end else if (asStart) begin
                        if (asSubtract) begin
                                asSum <= diffWide[W] ? diffFold[W-1:0] : diffWide[W-1:0];
                        end else begin
                                asSum <= sumOver ? sumFold[W-1:0] : sumWide[W-1:0];
                        end
                end
        end

endmodule

//--- logic/digitMultiplier.sv
`timescale 1ns/1ns

module digitMultiplier #(
        parameter int DigitWidth = 64
) (
        input  logic             clk,
        input  logic             start,
        input  logic             mulStart,
        input  fieldPkg::element mulA,
        input  fieldPkg::element mulB,
        output logic             mulBusy,
        output fieldPkg::product mulOut
);

        localparam int NumDigits = fieldPkg::ElementWidth / DigitWidth;
        localparam int IdxWidth  = $clog2(NumDigits);
        localparam int PairWidth = 2 * IdxWidth;

        fieldPkg::element        regA;
        fieldPkg::element        regB;
        fieldPkg::product        acc;
        logic [PairWidth-1:0]    pairCount;   // {digit of a, digit of b}
        logic [IdxWidth-1:0]     idxA;
        logic [IdxWidth-1:0]     idxB;
        logic [IdxWidth:0]       digitSum;
        logic [2*DigitWidth-1:0] partial;
        fieldPkg::product        partialShifted;

        assign idxA     = pairCount[PairWidth-1:IdxWidth];
        assign idxB     = pairCount[IdxWidth-1:0];
        assign digitSum = {1'b0, idxA} + {1'b0, idxB};

        ////////////////////////////////////////////////////////////////////////
        // one digit pair per cycle
        ////////////////////////////////////////////////////////////////////////

        assign partial = regA[idxA*DigitWidth +: DigitWidth] *
                         regB[idxB*DigitWidth +: DigitWidth];

        // weight of the pair is 2^((i+j)*d)
        assign partialShifted = fieldPkg::product'(partial) << (digitSum * DigitWidth);

        always_ff @(posedge clk or negedge start) begin
                if (!start) begin
                        mulBusy   <= 1'b0;
                        pairCount <= '0;
                end else if (mulStart) begin
                        mulBusy   <= 1'b1;
                        pairCount <= '0;
                end else if (mulBusy) begin
                        pairCount <= pairCount + 1'b1;
                        if (&pairCount) begin
                                mulBusy <= 1'b0;   // last pair accumulated
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (mulStart) begin
                        regA <= mulA;
                        regB <= mulB;
                        acc  <= '0;
                end else if (mulBusy) begin
                        acc <= acc + partialShifted;
                end
        end

        assign mulOut = acc;   // held after busy drops

endmodule

//--- logic/modReducer.sv
`timescale 1ns/1ns

module modReducer (
        input  logic             clk,
        input  logic             start,
        input  logic             redStart,
        input  fieldPkg::product redIn,
        output logic             redBusy,
        output fieldPkg::element redOut
);

        localparam int W          = fieldPkg::ElementWidth;
        localparam int P          = fieldPkg::ProductWidth;
        localparam int CountWidth = $clog2(P);

        fieldPkg::product      shiftReg;
        fieldPkg::element      rem;
        logic [CountWidth-1:0] bitCount;
        logic [W:0]            remShifted;
        logic [W:0]            remFolded;
        fieldPkg::element      remNext;

        ////////////////////////////////////////////////////////////////////////
        // remainder step: r = 2r + bit, minus p if r >= p
        ////////////////////////////////////////////////////////////////////////

        assign remShifted = {rem, shiftReg[P-1]};
        assign remFolded  = remShifted - {1'b0, fieldPkg::Prime};

        // r < p going in, so one subtract is enough
        assign remNext = (remShifted >= {1'b0, fieldPkg::Prime}) ?
                         remFolded[W-1:0] : remShifted[W-1:0];

        always_ff @(posedge clk or negedge start) begin
                if (!start) begin
                        redBusy  <= 1'b0;
                        bitCount <= '0;
                end else if (redStart) begin
                        redBusy  <= 1'b1;
                        bitCount <= '0;
                end else if (redBusy) begin
                        bitCount <= bitCount + 1'b1;
                        if (&bitCount) begin
                                redBusy <= 1'b0;   // lsb of product consumed
                        end
                end
        end

        // msb first
        always_ff @(posedge clk) begin
                if (redStart) begin
                        shiftReg <= redIn;
                        rem      <= '0;
                end else if (redBusy) begin
                        shiftReg <= {shiftReg[P-2:0], 1'b0};
                        rem      <= remNext;
                end
        end

        assign redOut = rem;

endmodule

//--- logic/fieldSequencer.sv
`timescale 1ns/1ns

module fieldSequencer (
        input  logic                   clk,
        input  logic                   start,
        input  commandPkg::fieldCmd    cmd,
        input  logic                   cmdValid,
        input  fieldPkg::element       asSum,
        input  logic                   mulBusy,
        input  fieldPkg::product       mulOut,
        input  logic                   redBusy,
        input  fieldPkg::element       redOut,
        output logic                   busy,
        output logic                   done,
        output commandPkg::fieldResult result,
        output logic                   asStart,
        output logic                   asSubtract,
        output fieldPkg::element       asA,
        output fieldPkg::element       asB,
        output logic                   mulStart,
        output fieldPkg::element       mulA,
        output fieldPkg::element       mulB,
        output logic                   redStart,
        output fieldPkg::product       redIn
);

        typedef enum logic [2:0] {
                sIdle,
                sIssue,     // decode and fire one unit
                sAsWait,
                sMulWait,
                sRedWait
        } seqState;

        seqState             state;
        commandPkg::fieldCmd cmdReg;
        logic                accept;
        logic                finish;
        fieldPkg::element    finishValue;

        assign accept = (state == sIdle) && cmdValid && !busy;

        // operands straight from the latched command
        assign asA        = cmdReg.a;
        assign asB        = cmdReg.b;
        assign asSubtract = (cmdReg.op == commandPkg::opSub);
        assign mulA       = cmdReg.a;
        assign mulB       = cmdReg.b;
        assign redIn      = mulOut;

        // a start pulse still high means the unit has not seen it yet
        assign finish = ((state == sAsWait) && !asStart) ||
                        ((state == sRedWait) && !redStart && !redBusy);
        assign finishValue = (state == sRedWait) ? redOut : asSum;

        always_ff @(posedge clk) begin
                if (accept) begin
                        cmdReg <= cmd;
                end
        end

        ////////////////////////////////////////////////////////////////////////
        // command FSM
        ////////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk or negedge start) begin
                if (!start) begin
                        state    <= sIdle;
                        busy     <= 1'b0;
                        done     <= 1'b0;
                        result   <= '0;
                        asStart  <= 1'b0;
                        mulStart <= 1'b0;
                        redStart <= 1'b0;
                end else begin
                        done     <= 1'b0;   // pulses only
                        asStart  <= 1'b0;
                        mulStart <= 1'b0;
                        redStart <= 1'b0;
                        if (finish) begin
                                result.value <= finishValue;
                                result.op    <= cmdReg.op;
                                done         <= 1'b1;
                                busy         <= 1'b0;
                                state        <= sIdle;
                        end else begin
                                case (state)
                                sIdle: begin
                                        if (accept) begin
                                                busy  <= 1'b1;
                                                state <= sIssue;
                                        end
                                end
                                sIssue: begin
                                        if (cmdReg.op == commandPkg::opMul) begin
                                                mulStart <= 1'b1;
                                                state    <= sMulWait;
                                        end else begin
                                                asStart <= 1'b1;
                                                state   <= sAsWait;
                                        end
                                end
                                sMulWait: begin
                                        if (!mulStart && !mulBusy) begin
                                                redStart <= 1'b1;   // product is held
                                                state    <= sRedWait;
                                        end
                                end
                                sAsWait, sRedWait: state <= state;
                                default: state <= sIdle;
                                endcase
                        end
                end
        end

endmodule

//--- logic/fieldUnit.sv
`timescale 1ns/1ns

module fieldUnit #(
        parameter int DigitWidth = 64
) (
        input  logic                   clk,
        input  logic                   start,
        input  commandPkg::fieldCmd    cmd,
        input  logic                   cmdValid,
        output logic                   busy,
        output logic                   done,
        output commandPkg::fieldResult result
);

        logic             asStart;
        logic             asSubtract;
        fieldPkg::element asA;
        fieldPkg::element asB;
        fieldPkg::element asSum;
        logic             mulStart;
        logic             mulBusy;
        fieldPkg::element mulA;
        fieldPkg::element mulB;
        fieldPkg::product mulOut;
        logic             redStart;
        logic             redBusy;
        fieldPkg::product redIn;
        fieldPkg::element redOut;

        fieldSequencer sequencer (
                .clk(clk), .start(start), .cmd(cmd), .cmdValid(cmdValid),
                .asSum(asSum), .mulBusy(mulBusy), .mulOut(mulOut),
                .redBusy(redBusy), .redOut(redOut), .busy(busy), .done(done),
                .result(result), .asStart(asStart), .asSubtract(asSubtract),
                .asA(asA), .asB(asB), .mulStart(mulStart), .mulA(mulA), .mulB(mulB),
                .redStart(redStart), .redIn(redIn)
        );

        modAddSub addSub (
                .clk(clk), .start(start), .asStart(asStart), .asSubtract(asSubtract),
                .asA(asA), .asB(asB), .asSum(asSum)
        );

        digitMultiplier #(.DigitWidth(DigitWidth)) multiplier (
                .clk(clk), .start(start), .mulStart(mulStart), .mulA(mulA),
                .mulB(mulB), .mulBusy(mulBusy), .mulOut(mulOut)
        );

        modReducer reducer (
                .clk(clk), .start(start), .redStart(redStart), .redIn(redIn),
                .redBusy(redBusy), .redOut(redOut)
        );

endmodule

//--- verification/fieldUnit_asserts.sv
`timescale 1ns/1ns

module fieldUnit_asserts (
        input logic clk,
        input logic start,
        input logic busy,
        input logic done,
        input logic asStart,
        input logic mulStart
);

        ////////////////////////////////////////////////////////////////////
        // sequencer handshake
        ////////////////////////////////////////////////////////////////////

        // done closes a busy stretch
        doneAfterBusy: assert property (
                @(posedge clk) disable iff (!start) done |-> $past(busy)
        ) else $error("done pulsed without busy in the previous cycle");

        busyDropsWithDone: assert property (
                @(posedge clk) disable iff (!start) $fell(busy) |-> done
        ) else $error("busy fell without a done pulse");

        // units fire only inside a command
        unitStartWhileBusy: assert property (
                @(posedge clk) disable iff (!start) (asStart || mulStart) |-> busy
        ) else $error("arithmetic unit started while the sequencer was idle");

endmodule

bind fieldSequencer fieldUnit_asserts sequencerAsserts (
        .clk(clk), .start(start), .busy(busy), .done(done),
        .asStart(asStart), .mulStart(mulStart)
);

//--- verification/fieldUnitTb.sv
`timescale 1ns/1ns

module fieldUnitTb;

        localparam int DigitWidth    = 64;
        localparam int ClockPeriod   = 100;
        localparam int NumDigits     = fieldPkg::ElementWidth / DigitWidth;
        localparam int CommandCycles = fieldPkg::ProductWidth + NumDigits * NumDigits + 20;
        localparam int NumCommands   = 32;   // directed plus random
        localparam int RandomCount   = 20;
        localparam int WatchdogTime  = NumCommands * CommandCycles * ClockPeriod;

        localparam fieldPkg::element BigA =
                256'h6b17d1f2_e12c4247_f8bce6e5_63a440f2_77037d81_2deb33a0_f4a13945_d898c296;
        localparam fieldPkg::element BigB =
                256'h4fe342e2_fe1a7f9b_8ee7eb4a_7c0f9e16_2bce3357_6b315ece_cbb64068_37bf51f5;

        logic                   clk;
        logic                   start;
        commandPkg::fieldCmd    cmd;
        logic                   cmdValid;
        logic                   busy;
        logic                   done;
        commandPkg::fieldResult result;

        int          valueErrors;
        int          otherErrors;

        fieldUnit #(.DigitWidth(DigitWidth)) UUT (
                .clk(clk), .start(start), .cmd(cmd), .cmdValid(cmdValid),
                .busy(busy), .done(done), .result(result)
        );

        always #(ClockPeriod / 2) clk = ~clk;

        ////////////////////////////////////////////////////////////////////
        // reference model and compares
        ////////////////////////////////////////////////////////////////////

        function automatic fieldPkg::element expectedValue(input commandPkg::fieldOp op,
                                                           input fieldPkg::element a,
                                                           input fieldPkg::element b);
                fieldPkg::product wa;
                fieldPkg::product wb;
                fieldPkg::product wp;
                fieldPkg::product r;
                wa = a;
                wb = b;
                wp = fieldPkg::Prime;
                case (op)
                commandPkg::opAdd: r = (wa + wb) % wp;
                commandPkg::opSub: r = (wa + wp - wb) % wp;   // keep it positive
                default:           r = (wa * wb) % wp;
                endcase
                return r[fieldPkg::ElementWidth-1:0];
        endfunction

        function automatic fieldPkg::element randomElement();
                fieldPkg::element v;
                for (int i = 0; i < fieldPkg::ElementWidth / 32; i++) begin
                        v[i*32 +: 32] = $urandom;
                end
                return v % fieldPkg::Prime;
        endfunction

        task automatic checkElement(input string name, input fieldPkg::element got,
                                    input fieldPkg::element wanted);
                if (got !== wanted) begin
                        $display("Fail %s: got %h, expected %h", name, got, wanted);
                        valueErrors++;
                end
        endtask

        task automatic checkOp(input string name, input commandPkg::fieldOp got,
                               input commandPkg::fieldOp wanted);
                if (got !== wanted) begin
                        $display("Fail %s: got %h, expected %h", name, got, wanted);
                        valueErrors++;
                end
        endtask

        task automatic checkBit(input string name, input logic got, input logic wanted);
                if (got !== wanted) begin
                        $display("Fail %s: got %h, expected %h", name, got, wanted);
                        valueErrors++;
                end
        endtask

        ////////////////////////////////////////////////////////////////////
        // command helpers
        ////////////////////////////////////////////////////////////////////

        // returns on the acceptance edge
        task automatic sendCommand(input commandPkg::fieldOp op, input fieldPkg::element a,
                                   input fieldPkg::element b);
                commandPkg::fieldCmd c;
                c.op = op;
                c.a  = a;
                c.b  = b;
                @(posedge clk);
                cmd      <= c;
                cmdValid <= 1'b1;
                @(posedge clk);
                cmdValid <= 1'b0;
        endtask

        task automatic waitForDone(output int latency);
                int cycles;
                bit seen;
                seen    = 1'b0;
                latency = -1;
                cycles  = 0;
                while (!seen && cycles < CommandCycles) begin
                        @(negedge clk);
                        if (done) begin
                                seen    = 1'b1;
                                latency = cycles;   // edges after acceptance
                                checkBit("busy", busy, 1'b0);   // falls with done
                        end else begin
                                checkBit("busy", busy, 1'b1);
                        end
                        cycles++;
                end
                if (!seen) begin
                        $display("done never arrived within %0d cycles", CommandCycles);
                        otherErrors++;
                end
        endtask

        task automatic runCommand(input commandPkg::fieldOp op, input fieldPkg::element a,
                                  input fieldPkg::element b);
                fieldPkg::element wanted;
                int latency;
                wanted = expectedValue(op, a, b);
                sendCommand(op, a, b);
                waitForDone(latency);
                if (latency >= 0) begin
                        checkElement("result.value", result.value, wanted);
                        checkOp("result.op", result.op, op);
                        if (op != commandPkg::opMul && latency != 3) begin
                                $display("add or subtract finished after %0d cycles, not 3",
                                         latency);
                                otherErrors++;
                        end
                        @(negedge clk);
                        checkBit("done", done, 1'b0);   // single pulse
                        checkElement("result.value", result.value, wanted);
                end
        endtask

        ////////////////////////////////////////////////////////////////////
        // directed tests
        ////////////////////////////////////////////////////////////////////

        task automatic resetTest();
                for (int i = 0; i < 10; i++) begin
                        @(negedge clk);
                        checkBit("busy", busy, 1'b0);
                        checkBit("done", done, 1'b0);
                        checkElement("result.value", result.value, '0);
                        checkOp("result.op", result.op, commandPkg::opAdd);   // zero code
                end
                @(posedge clk);
                start <= 1'b1;
                @(negedge clk);
                checkBit("busy", busy, 1'b0);
                checkBit("done", done, 1'b0);
                checkElement("result.value", result.value, '0);
                checkOp("result.op", result.op, commandPkg::opAdd);
        endtask

        task automatic additionTest();
                runCommand(commandPkg::opAdd, 256'd5, 256'd7);
                runCommand(commandPkg::opAdd, fieldPkg::Prime - 1, 256'd5);   // wraps to 4
                runCommand(commandPkg::opAdd, fieldPkg::Prime - 2, 256'd2);
        endtask

        task automatic subtractionTest();
                runCommand(commandPkg::opSub, 256'd100, 256'd58);
                runCommand(commandPkg::opSub, 256'd3, 256'd7);   // p - 4
                runCommand(commandPkg::opSub, BigA, BigA);
        endtask

        task automatic multiplicationTest();
                runCommand(commandPkg::opMul, BigA, 256'd0);
                runCommand(commandPkg::opMul, BigB, 256'd1);
                runCommand(commandPkg::opMul, fieldPkg::Prime - 1, fieldPkg::Prime - 1);
                runCommand(commandPkg::opMul, BigA, BigB);
        endtask

        task automatic ignoredCommandTest();
                commandPkg::fieldCmd other;
                fieldPkg::element wanted;
                int latency;
                int extraDone;
                wanted    = expectedValue(commandPkg::opMul, BigB, BigA);
                other.op  = commandPkg::opAdd;
                other.a   = 256'd1;
                other.b   = 256'd2;
                extraDone = 0;
                sendCommand(commandPkg::opMul, BigB, BigA);
                @(posedge clk);
                cmd      <= other;   // arrives while busy
                cmdValid <= 1'b1;
                repeat (4) @(posedge clk);
                cmdValid <= 1'b0;
                waitForDone(latency);
                if (latency >= 0) begin
                        checkElement("result.value", result.value, wanted);
                        checkOp("result.op", result.op, commandPkg::opMul);
                end
                repeat (20) begin
                        @(negedge clk);
                        if (done) extraDone++;
                        checkBit("busy", busy, 1'b0);
                end
                if (extraDone != 0) begin
                        $display("ignored command still produced %0d done pulses", extraDone);
                        otherErrors++;
                end
        endtask

        task automatic randomCommandTest();
                commandPkg::fieldOp op;
                fieldPkg::element a;
                fieldPkg::element b;
                for (int n = 0; n < RandomCount; n++) begin
                        op = commandPkg::fieldOp'($urandom_range(2, 0));
                        a  = randomElement();
                        b  = randomElement();
                        runCommand(op, a, b);
                end
        endtask

        initial begin
                #(WatchdogTime);
                $display("watchdog expired before the tests finished");
                $display("SOME TESTS FAILED");
                $finish;
        end

        initial begin
                clk         = 1'b0;
                start       = 1'b0;
                cmdValid    = 1'b0;
                cmd         = '0;
                valueErrors = 0;
                otherErrors = 0;
                void'($urandom(32'ha7cf_30e2));
                resetTest();
                additionTest();
                subtractionTest();
                multiplicationTest();
                ignoredCommandTest();
                randomCommandTest();
                $display("errors: %0d wrong values, %0d other", valueErrors, otherErrors);
                if (valueErrors + otherErrors == 0) begin
                        $display("ALL TESTS PASSED");
                end else begin
                        $display("SOME TESTS FAILED");
                end
                $finish;
        end

endmodule

//--- list.f
logic/fieldPkg.sv
logic/commandPkg.sv
logic/modAddSub.sv
logic/digitMultiplier.sv
logic/modReducer.sv
logic/fieldSequencer.sv
logic/fieldUnit.sv
verification/fieldUnit_asserts.sv
verification/fieldUnitTb.sv

//--- Makefile
# Verilator simulation of the P-256 field unit

VERILATOR ?= verilator
TOP       ?= fieldUnitTb
SEED      ?= 1
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FILELIST  ?= list.f

.PHONY: sim clean

# pass only if the testbench printed its pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) +verilator+seed+$(SEED) | tee /dev/stderr | \
		grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
